// ==== source/decode_config.svh ====
// widths, register count and bubble marker values
// for the RV32I decode stage
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

`define DEC_XLEN      32
`define DEC_REG_AW    5
`define DEC_NUM_REGS  32

// addi x0, x0, 0
`define DEC_INST_NOP  32'h0000_0013
`define DEC_PC_NOP    32'hffff_ffff

`endif

// ==== source/decode_pkg.sv ====
// decode stage types
// alu, operand select, memory and writeback encodings
// control bundle passed to execute
package decode_pkg;

    typedef enum logic [4:0] {
        ALU_ADD  = 5'd0,   // zero so a cleared bundle is a plain add
        ALU_SUB  = 5'd1,
        ALU_AND  = 5'd2,
        ALU_OR   = 5'd3,
        ALU_XOR  = 5'd4,
        ALU_SLL  = 5'd5,
        ALU_SRL  = 5'd6,
        ALU_SRA  = 5'd7,
        ALU_SLT  = 5'd8,
        ALU_SLTU = 5'd9,
        ALU_JALR = 5'd10,
        BR_BEQ   = 5'd11,
        BR_BNE   = 5'd12,
        BR_BLT   = 5'd13,
        BR_BGE   = 5'd14,
        BR_BLTU  = 5'd15,
        BR_BGEU  = 5'd16
    } alu_op_e;

    typedef enum logic [1:0] {
        OP1_RS1  = 2'd0,
        OP1_PC   = 2'd1,
        OP1_NONE = 2'd2
    } op1_sel_e;

    typedef enum logic [2:0] {
        OP2_RS2  = 3'd0,
        OP2_IMI  = 3'd1,
        OP2_IMS  = 3'd2,
        OP2_IMJ  = 3'd3,
        OP2_IMU  = 3'd4,
        OP2_NONE = 3'd5
    } op2_sel_e;

    typedef enum logic [3:0] {
        MEM_NONE, MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW, MEM_SB, MEM_SH, MEM_SW
    } mem_op_e;

    typedef enum logic [1:0] {
        WB_NONE, WB_ALU, WB_MEM, WB_PC
    } wb_sel_e;

    typedef struct packed {
        alu_op_e alu_op;
        mem_op_e mem_op;
        wb_sel_e wb_sel;
        logic    rf_wen;
        logic    jmp_flg;   // jal or jalr
    } ctrl_t;

endpackage

// ==== source/instr_decoder.sv ====
// RV32I decode table
// register field extraction and sign-extended immediates
// unknown encodings give the nop bundle
`include "decode_config.svh"

module instr_decoder (
    input  logic [`DEC_XLEN-1:0]   cur_inst,
    output logic [`DEC_REG_AW-1:0] rs1_addr,
    output logic [`DEC_REG_AW-1:0] rs2_addr,
    output logic [`DEC_REG_AW-1:0] rd_addr,
    output decode_pkg::op1_sel_e   op1_sel,
    output decode_pkg::op2_sel_e   op2_sel,
    output decode_pkg::ctrl_t      ctrl,
    output logic [`DEC_XLEN-1:0]   imm_i,
    output logic [`DEC_XLEN-1:0]   imm_s,
    output logic [`DEC_XLEN-1:0]   imm_b,
    output logic [`DEC_XLEN-1:0]   imm_j,
    output logic [`DEC_XLEN-1:0]   imm_u
);

    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       valid;
    decode_pkg::alu_op_e  alu;
    decode_pkg::mem_op_e  mem;
    decode_pkg::wb_sel_e  wb;
    decode_pkg::op1_sel_e o1;
    decode_pkg::op2_sel_e o2;

    assign opcode   = cur_inst[6:0];
    assign funct3   = cur_inst[14:12];
    assign funct7   = cur_inst[31:25];
    assign rs1_addr = cur_inst[19:15];
    assign rs2_addr = cur_inst[24:20];
    assign rd_addr  = cur_inst[11:7];

    assign imm_i = {{20{cur_inst[31]}}, cur_inst[31:20]};
    assign imm_s = {{20{cur_inst[31]}}, cur_inst[31:25], cur_inst[11:7]};
    assign imm_b = {{19{cur_inst[31]}}, cur_inst[31], cur_inst[7], cur_inst[30:25],
                    cur_inst[11:8], 1'b0};
    assign imm_j = {{11{cur_inst[31]}}, cur_inst[31], cur_inst[19:12], cur_inst[20],
                    cur_inst[30:21], 1'b0};
    assign imm_u = {cur_inst[31:12], 12'b0};

    always_comb begin
        valid = 1'b1;
        alu   = decode_pkg::ALU_ADD;
        mem   = decode_pkg::MEM_NONE;
        wb    = decode_pkg::WB_ALU;
        o1    = decode_pkg::OP1_RS1;
        o2    = decode_pkg::OP2_RS2;
        case (opcode)
            OPC_LOAD: begin
                o2 = decode_pkg::OP2_IMI;
                wb = decode_pkg::WB_MEM;
                case (funct3)
                    3'b000:  mem = decode_pkg::MEM_LB;
                    3'b001:  mem = decode_pkg::MEM_LH;
                    3'b010:  mem = decode_pkg::MEM_LW;
                    3'b100:  mem = decode_pkg::MEM_LBU;
                    3'b101:  mem = decode_pkg::MEM_LHU;
                    default: valid = 1'b0;
                endcase
            end
            OPC_STORE: begin
                o2 = decode_pkg::OP2_IMS;
                wb = decode_pkg::WB_NONE;
                case (funct3)
                    3'b000:  mem = decode_pkg::MEM_SB;
                    3'b001:  mem = decode_pkg::MEM_SH;
                    3'b010:  mem = decode_pkg::MEM_SW;
                    default: valid = 1'b0;
                endcase
            end
            OPC_OPIMM, OPC_OP: begin
                if (opcode == OPC_OPIMM)
                    o2 = decode_pkg::OP2_IMI;
                case (funct3)
                    3'b000:  alu = (opcode == OPC_OP && funct7[5]) ? decode_pkg::ALU_SUB
                                                                   : decode_pkg::ALU_ADD;
                    3'b001:  alu = decode_pkg::ALU_SLL;
                    3'b010:  alu = decode_pkg::ALU_SLT;
                    3'b011:  alu = decode_pkg::ALU_SLTU;
                    3'b100:  alu = decode_pkg::ALU_XOR;
                    3'b101:  alu = funct7[5] ? decode_pkg::ALU_SRA : decode_pkg::ALU_SRL;
                    3'b110:  alu = decode_pkg::ALU_OR;
                    default: alu = decode_pkg::ALU_AND;
                endcase
                // funct7 only legal as 0 or 0x20, and 0x20 only on sub/sra/srai
                if (opcode == OPC_OP || funct3 == 3'b001 || funct3 == 3'b101)
                    valid = (funct7 == 7'b0) ||
                            (funct7 == 7'b0100000 && (funct3 == 3'b101 ||
                                                      (opcode == OPC_OP && funct3 == 3'b000)));
            end
            OPC_BRANCH: begin
                wb = decode_pkg::WB_NONE;
                case (funct3)
                    3'b000:  alu = decode_pkg::BR_BEQ;
                    3'b001:  alu = decode_pkg::BR_BNE;
                    3'b100:  alu = decode_pkg::BR_BLT;
                    3'b101:  alu = decode_pkg::BR_BGE;
                    3'b110:  alu = decode_pkg::BR_BLTU;
                    3'b111:  alu = decode_pkg::BR_BGEU;
                    default: valid = 1'b0;
                endcase
            end
            OPC_JAL: begin
                o1 = decode_pkg::OP1_PC;
                o2 = decode_pkg::OP2_IMJ;
                wb = decode_pkg::WB_PC;
            end
            OPC_JALR: begin
                alu   = decode_pkg::ALU_JALR;
                o2    = decode_pkg::OP2_IMI;
                wb    = decode_pkg::WB_PC;
                valid = (funct3 == 3'b000);
            end
            OPC_LUI, OPC_AUIPC: begin
                o1 = (opcode == OPC_LUI) ? decode_pkg::OP1_NONE : decode_pkg::OP1_PC;
                o2 = decode_pkg::OP2_IMU;
            end
            default: valid = 1'b0;
        endcase

        if (valid) begin
            ctrl    = '{alu, mem, wb, wb != decode_pkg::WB_NONE, wb == decode_pkg::WB_PC};
            op1_sel = o1;
            op2_sel = o2;
        end else begin
            ctrl    = '0;   // nop bundle
            op1_sel = decode_pkg::OP1_NONE;
            op2_sel = decode_pkg::OP2_NONE;
        end
    end

endmodule

// ==== source/hazard_unit.sv ====
// data hazard detection against exe, mem and wb writers
// stall merge with the memory stage
// save buffer for replay, and nop injection on flush
`include "decode_config.svh"

module hazard_unit (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic [`DEC_XLEN-1:0]   inst,
    input  logic [`DEC_XLEN-1:0]   pc,
    input  logic                   mem_stall,
    input  logic                   flush,
    input  logic [`DEC_REG_AW-1:0] rs1_addr,
    input  logic [`DEC_REG_AW-1:0] rs2_addr,
    input  logic                   exe_rf_wen,
    input  logic [`DEC_REG_AW-1:0] exe_wb_addr,
    input  logic                   mem_rf_wen,
    input  logic [`DEC_REG_AW-1:0] mem_wb_addr,
    input  logic                   wb_rf_wen,
    input  logic [`DEC_REG_AW-1:0] wb_wb_addr,
    output logic [`DEC_XLEN-1:0]   cur_inst,
    output logic [`DEC_XLEN-1:0]   cur_pc,
    output logic                   hazard_stall,
    output logic                   stage_stall
);

    logic [2:0]          hit;
    logic                replay;
    logic [`DEC_XLEN-1:0] save_inst;
    logic [`DEC_XLEN-1:0] save_pc;

    // sources compared even when the instruction ignores them
    assign hit[0] = exe_rf_wen && exe_wb_addr != '0 &&
                    (exe_wb_addr == rs1_addr || exe_wb_addr == rs2_addr);
    assign hit[1] = mem_rf_wen && mem_wb_addr != '0 &&
                    (mem_wb_addr == rs1_addr || mem_wb_addr == rs2_addr);
    assign hit[2] = wb_rf_wen && wb_wb_addr != '0 &&
                    (wb_wb_addr == rs1_addr || wb_wb_addr == rs2_addr);

    assign hazard_stall = !flush && (|hit);
    assign stage_stall  = mem_stall || hazard_stall;

    assign cur_inst = flush ? `DEC_INST_NOP : (replay ? save_inst : inst);
    assign cur_pc   = flush ? `DEC_PC_NOP   : (replay ? save_pc : pc);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            replay <= 1'b0;
        else
            replay <= stage_stall;
    end

    always_ff @(posedge clk) begin
        if (stage_stall) begin
            save_inst <= cur_inst;   // held for the next cycle
            save_pc   <= cur_pc;
        end else if (flush) begin
            save_inst <= `DEC_INST_NOP;
            save_pc   <= `DEC_PC_NOP;
        end
    end

    // a flushed instruction is never held for replay
    a_flush_no_hold: assert property (@(posedge clk) disable iff (!arst_n)
        flush |-> !hazard_stall ##1 (!replay || cur_inst == `DEC_INST_NOP || flush));

endmodule

// ==== source/reg_file.sv ====
// 32-entry integer register file
// one write port, two combinational read ports, x0 hardwired to zero
`include "decode_config.svh"

module reg_file (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   wen,
    input  logic [`DEC_REG_AW-1:0] waddr,
    input  logic [`DEC_XLEN-1:0]   wdata,
    input  logic [`DEC_REG_AW-1:0] raddr_a,
    input  logic [`DEC_REG_AW-1:0] raddr_b,
    output logic [`DEC_XLEN-1:0]   rdata_a,
    output logic [`DEC_XLEN-1:0]   rdata_b
);

    logic [`DEC_XLEN-1:0] regs [`DEC_NUM_REGS];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `DEC_NUM_REGS; i++)
                regs[i] <= '0;
        end else if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // no bypass, same-cycle read sees the old value
    assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

    a_waddr_range: assert property (@(posedge clk) disable iff (!arst_n)
        wen |-> (int'(waddr) < `DEC_NUM_REGS));

endmodule

// ==== source/issue_register.sv ====
// ALU operand selection
// registered decode bundle with bubble insertion on stall
`include "decode_config.svh"

module issue_register (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   stage_stall,
    input  logic [`DEC_XLEN-1:0]   cur_inst,
    input  logic [`DEC_XLEN-1:0]   cur_pc,
    input  decode_pkg::op1_sel_e   op1_sel,
    input  decode_pkg::op2_sel_e   op2_sel,
    input  decode_pkg::ctrl_t      ctrl_in,
    input  logic [`DEC_REG_AW-1:0] rd_addr,
    input  logic [`DEC_XLEN-1:0]   rs1_data,
    input  logic [`DEC_XLEN-1:0]   rs2_data_in,
    input  logic [`DEC_XLEN-1:0]   imm_i,
    input  logic [`DEC_XLEN-1:0]   imm_s,
    input  logic [`DEC_XLEN-1:0]   imm_b_in,
    input  logic [`DEC_XLEN-1:0]   imm_j,
    input  logic [`DEC_XLEN-1:0]   imm_u,
    output logic [`DEC_XLEN-1:0]   out_inst,
    output logic [`DEC_XLEN-1:0]   out_pc,
    output logic [`DEC_XLEN-1:0]   op1_data,
    output logic [`DEC_XLEN-1:0]   op2_data,
    output logic [`DEC_XLEN-1:0]   rs2_data,
    output logic [`DEC_XLEN-1:0]   imm_b,
    output decode_pkg::ctrl_t      ctrl,
    output logic [`DEC_REG_AW-1:0] wb_addr
);

    logic [`DEC_XLEN-1:0] op1_nxt;
    logic [`DEC_XLEN-1:0] op2_nxt;

    always_comb begin
        case (op1_sel)
            decode_pkg::OP1_RS1: op1_nxt = rs1_data;
            decode_pkg::OP1_PC:  op1_nxt = cur_pc;
            default:             op1_nxt = '0;   // lui
        endcase
        case (op2_sel)
            decode_pkg::OP2_RS2: op2_nxt = rs2_data_in;
            decode_pkg::OP2_IMI: op2_nxt = imm_i;
            decode_pkg::OP2_IMS: op2_nxt = imm_s;
            decode_pkg::OP2_IMJ: op2_nxt = imm_j;
            decode_pkg::OP2_IMU: op2_nxt = imm_u;
            default:             op2_nxt = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_inst <= `DEC_INST_NOP;
            out_pc   <= `DEC_PC_NOP;
            op1_data <= '1;
            op2_data <= '1;
            rs2_data <= '1;
            imm_b    <= '1;
            ctrl     <= '0;
            wb_addr  <= '0;
        end else begin
            // bubble on stall
            out_inst <= stage_stall ? `DEC_INST_NOP : cur_inst;
            out_pc   <= stage_stall ? `DEC_PC_NOP : cur_pc;
            op1_data <= stage_stall ? '1 : op1_nxt;
            op2_data <= stage_stall ? '1 : op2_nxt;
            rs2_data <= stage_stall ? '1 : rs2_data_in;
            imm_b    <= stage_stall ? '1 : imm_b_in;
            ctrl     <= stage_stall ? '0 : ctrl_in;
            wb_addr  <= stage_stall ? '0 : rd_addr;
        end
    end

    a_bubble_no_write: assert property (@(posedge clk) disable iff (!arst_n)
        stage_stall |=> !ctrl.rf_wen);

endmodule

// ==== source/decode_top.sv ====
// decode stage top
// hazard unit, instruction decoder, register file and issue register
`include "decode_config.svh"

module decode_top (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic [`DEC_XLEN-1:0]   inst,
    input  logic [`DEC_XLEN-1:0]   pc,
    input  logic                   mem_stall,
    input  logic                   flush,
    input  logic                   exe_rf_wen,
    input  logic                   mem_rf_wen,
    input  logic                   wb_rf_wen,
    input  logic [`DEC_REG_AW-1:0] exe_wb_addr,
    input  logic [`DEC_REG_AW-1:0] mem_wb_addr,
    input  logic [`DEC_REG_AW-1:0] wb_wb_addr,
    input  logic                   wb_wen,
    input  logic [`DEC_REG_AW-1:0] wb_waddr,
    input  logic [`DEC_XLEN-1:0]   wb_wdata,
    output logic                   hazard_stall,
    output logic [`DEC_XLEN-1:0]   out_inst,
    output logic [`DEC_XLEN-1:0]   out_pc,
    output logic [`DEC_XLEN-1:0]   op1_data,
    output logic [`DEC_XLEN-1:0]   op2_data,
    output logic [`DEC_XLEN-1:0]   rs2_data,
    output logic [`DEC_XLEN-1:0]   imm_b,
    output decode_pkg::ctrl_t      ctrl,
    output logic [`DEC_REG_AW-1:0] wb_addr
);

    logic [`DEC_XLEN-1:0]   cur_inst, cur_pc;
    logic                   stage_stall;
    logic [`DEC_REG_AW-1:0] rs1_addr, rs2_addr, rd_addr;
    decode_pkg::op1_sel_e   op1_sel;
    decode_pkg::op2_sel_e   op2_sel;
    decode_pkg::ctrl_t      dec_ctrl;
    logic [`DEC_XLEN-1:0]   imm_i, imm_s, dec_imm_b, imm_j, imm_u;
    logic [`DEC_XLEN-1:0]   rs1_val, rs2_val;

    hazard_unit u_hazard (
        .clk, .arst_n, .inst, .pc, .mem_stall, .flush, .rs1_addr, .rs2_addr,
        .exe_rf_wen, .exe_wb_addr, .mem_rf_wen, .mem_wb_addr, .wb_rf_wen, .wb_wb_addr,
        .cur_inst, .cur_pc, .hazard_stall, .stage_stall
    );

    instr_decoder u_decoder (
        .cur_inst, .rs1_addr, .rs2_addr, .rd_addr, .op1_sel, .op2_sel,
        .ctrl(dec_ctrl), .imm_i, .imm_s, .imm_b(dec_imm_b), .imm_j, .imm_u
    );

    reg_file u_reg_file (
        .clk, .arst_n, .wen(wb_wen), .waddr(wb_waddr), .wdata(wb_wdata),
        .raddr_a(rs1_addr), .raddr_b(rs2_addr), .rdata_a(rs1_val), .rdata_b(rs2_val)
    );

    issue_register u_issue (
        .clk, .arst_n, .stage_stall, .cur_inst, .cur_pc, .op1_sel, .op2_sel,
        .ctrl_in(dec_ctrl), .rd_addr, .rs1_data(rs1_val), .rs2_data_in(rs2_val),
        .imm_i, .imm_s, .imm_b_in(dec_imm_b), .imm_j, .imm_u,
        .out_inst, .out_pc, .op1_data, .op2_data, .rs2_data, .imm_b, .ctrl, .wb_addr
    );

endmodule

// ==== verif/tb_clock_gen.sv ====
// testbench clock and reset
// 8 ns clock, reset held low for 16 cycles
module tb_clock_gen (
    output logic clk,
    output logic arst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;
    end

endmodule

// ==== verif/tb_decode.sv ====
// decode stage testbench
// register shadow, reference decoder, expected-bundle queue and comparator
// random decode, hazard, memory stall and flush sequences
`include "decode_config.svh"

module tb_decode;
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic [31:0]       inst;
        logic [31:0]       pc;
        logic [31:0]       op1;
        logic [31:0]       op2;
        logic [31:0]       rs2;
        logic [31:0]       imm_b;
        decode_pkg::ctrl_t ctrl;
        logic [4:0]        wb_addr;
    } bundle_t;

    typedef struct {
        int      due;
        bundle_t b;
    } exp_item_t;

    logic                   clk, arst_n;
    logic [`DEC_XLEN-1:0]   inst, pc, wb_wdata;
    logic                   mem_stall, flush, wb_wen;
    logic                   exe_rf_wen, mem_rf_wen, wb_rf_wen;
    logic [`DEC_REG_AW-1:0] exe_wb_addr, mem_wb_addr, wb_wb_addr, wb_waddr;
    logic                   hazard_stall;
    logic [`DEC_XLEN-1:0]   out_inst, out_pc, op1_data, op2_data, rs2_data, imm_b;
    decode_pkg::ctrl_t      ctrl;
    logic [`DEC_REG_AW-1:0] wb_addr;

    logic [31:0] shadow [32];
    exp_item_t   exp_q [$];
    int          ncount = 0;
    int          check_errs = 0;
    int          timeout_errs = 0;

    tb_clock_gen u_clk (.clk, .arst_n);

    decode_top DUT (
        .clk, .arst_n, .inst, .pc, .mem_stall, .flush,
        .exe_rf_wen, .mem_rf_wen, .wb_rf_wen, .exe_wb_addr, .mem_wb_addr, .wb_wb_addr,
        .wb_wen, .wb_waddr, .wb_wdata, .hazard_stall,
        .out_inst, .out_pc, .op1_data, .op2_data, .rs2_data, .imm_b, .ctrl, .wb_addr
    );

    function automatic bundle_t bubble();
        bundle_t b;
        b = '1;
        b.inst = `DEC_INST_NOP;
        b.pc = `DEC_PC_NOP;
        b.ctrl = '0;
        b.wb_addr = '0;
        return b;
    endfunction

    // expected bundle from the RV32I encoding rules
    function automatic bundle_t decode_ref(input logic [31:0] i, input logic [31:0] p);
        bundle_t b;
        logic [6:0] opc, f7;
        logic [2:0] f3;
        logic [31:0] r1, r2, ii, is, ib, ij, iu;
        logic ok;
        logic wr;
        logic jf;
        decode_pkg::alu_op_e alu;
        decode_pkg::mem_op_e mo;
        decode_pkg::wb_sel_e wb;
        decode_pkg::op1_sel_e s1;
        decode_pkg::op2_sel_e s2;
        opc = i[6:0];
        f3 = i[14:12];
        f7 = i[31:25];
        r1 = (i[19:15] == 5'd0) ? 32'd0 : shadow[i[19:15]];
        r2 = (i[24:20] == 5'd0) ? 32'd0 : shadow[i[24:20]];
        ii = {{20{i[31]}}, i[31:20]};
        is = {{20{i[31]}}, i[31:25], i[11:7]};
        ib = {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
        ij = {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
        iu = {i[31:12], 12'd0};
        ok = 1'b1;
        wr = 1'b1;   // everything but stores and branches writes rd
        jf = 1'b0;
        alu = decode_pkg::ALU_ADD;
        mo = decode_pkg::MEM_NONE;
        wb = decode_pkg::WB_ALU;
        s1 = decode_pkg::OP1_RS1;
        s2 = decode_pkg::OP2_RS2;
        case (opc)
            7'h03: begin
                s2 = decode_pkg::OP2_IMI;
                wb = decode_pkg::WB_MEM;
                case (f3)
                    3'd0: mo = decode_pkg::MEM_LB;
                    3'd1: mo = decode_pkg::MEM_LH;
                    3'd2: mo = decode_pkg::MEM_LW;
                    3'd4: mo = decode_pkg::MEM_LBU;
                    3'd5: mo = decode_pkg::MEM_LHU;
                    default: ok = 1'b0;
                endcase
            end
            7'h23: begin
                s2 = decode_pkg::OP2_IMS;
                wb = decode_pkg::WB_NONE;
                wr = 1'b0;
                case (f3)
                    3'd0: mo = decode_pkg::MEM_SB;
                    3'd1: mo = decode_pkg::MEM_SH;
                    3'd2: mo = decode_pkg::MEM_SW;
                    default: ok = 1'b0;
                endcase
            end
            7'h13, 7'h33: begin
                case (f3)
                    3'd0: alu = (opc == 7'h33 && f7 == 7'h20) ? decode_pkg::ALU_SUB
                                                              : decode_pkg::ALU_ADD;
                    3'd1: alu = decode_pkg::ALU_SLL;
                    3'd2: alu = decode_pkg::ALU_SLT;
                    3'd3: alu = decode_pkg::ALU_SLTU;
                    3'd4: alu = decode_pkg::ALU_XOR;
                    3'd5: alu = (f7 == 7'h20) ? decode_pkg::ALU_SRA : decode_pkg::ALU_SRL;
                    3'd6: alu = decode_pkg::ALU_OR;
                    default: alu = decode_pkg::ALU_AND;
                endcase
                if (opc == 7'h13) begin
                    s2 = decode_pkg::OP2_IMI;
                    if (f3 == 3'd1)
                        ok = (f7 == 7'h00);
                    if (f3 == 3'd5)
                        ok = (f7 == 7'h00) || (f7 == 7'h20);
                end else begin
                    ok = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
                end
            end
            7'h63: begin
                wb = decode_pkg::WB_NONE;
                wr = 1'b0;
                case (f3)
                    3'd0: alu = decode_pkg::BR_BEQ;
                    3'd1: alu = decode_pkg::BR_BNE;
                    3'd4: alu = decode_pkg::BR_BLT;
                    3'd5: alu = decode_pkg::BR_BGE;
                    3'd6: alu = decode_pkg::BR_BLTU;
                    3'd7: alu = decode_pkg::BR_BGEU;
                    default: ok = 1'b0;
                endcase
            end
            7'h6f: begin
                s1 = decode_pkg::OP1_PC;
                s2 = decode_pkg::OP2_IMJ;
                wb = decode_pkg::WB_PC;
                jf = 1'b1;
            end
            7'h67: begin
                alu = decode_pkg::ALU_JALR;
                s2 = decode_pkg::OP2_IMI;
                wb = decode_pkg::WB_PC;
                jf = 1'b1;
                ok = (f3 == 3'd0);
            end
            7'h37: begin
                s1 = decode_pkg::OP1_NONE;
                s2 = decode_pkg::OP2_IMU;
            end
            7'h17: begin
                s1 = decode_pkg::OP1_PC;
                s2 = decode_pkg::OP2_IMU;
            end
            default: ok = 1'b0;
        endcase
        b.inst = i;
        b.pc = p;
        b.rs2 = r2;
        b.imm_b = ib;
        b.wb_addr = i[11:7];
        b.ctrl = '0;
        b.op1 = '0;
        b.op2 = '0;
        if (ok) begin
            b.ctrl.alu_op = alu;
            b.ctrl.mem_op = mo;
            b.ctrl.wb_sel = wb;
            b.ctrl.rf_wen = wr;
            b.ctrl.jmp_flg = jf;
            if (s1 == decode_pkg::OP1_RS1)
                b.op1 = r1;
            else if (s1 == decode_pkg::OP1_PC)
                b.op1 = p;
            case (s2)
                decode_pkg::OP2_RS2: b.op2 = r2;
                decode_pkg::OP2_IMI: b.op2 = ii;
                decode_pkg::OP2_IMS: b.op2 = is;
                decode_pkg::OP2_IMJ: b.op2 = ij;
                decode_pkg::OP2_IMU: b.op2 = iu;
                default: b.op2 = '0;
            endcase
        end
        return b;
    endfunction

    // kept opcodes plus a few unsupported ones
    function automatic logic [31:0] rand_inst();
        logic [31:0] w;
        int k;
        w = $urandom;
        k = $urandom_range(0, 11);
        case (k)
            0: w[6:0] = 7'h03;
            1: w[6:0] = 7'h23;
            2: w[6:0] = 7'h13;
            3: w[6:0] = 7'h33;
            4: w[6:0] = 7'h63;
            5: w[6:0] = 7'h6f;
            6: w[6:0] = 7'h67;
            7: w[6:0] = 7'h37;
            8: w[6:0] = 7'h17;
            9: w[6:0] = 7'h73;   // system
            10: w[6:0] = 7'h0f;  // fence
            default: w[6:0] = 7'h7f;
        endcase
        if (k == 2 || k == 3)
            w[31:25] = ($urandom_range(0, 1) == 1) ? 7'h20 : 7'h00;
        if (k == 6 && $urandom_range(0, 3) != 0)
            w[14:12] = 3'd0;
        return w;
    endfunction

    function automatic logic [31:0] rand_pc();
        logic [31:0] r;
        r = $urandom;
        return {r[31:2], 2'b00};
    endfunction

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            check_errs++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bundle(input bundle_t e);
        check_field("out_inst", out_inst, e.inst);
        check_field("out_pc", out_pc, e.pc);
        check_field("op1_data", op1_data, e.op1);
        check_field("op2_data", op2_data, e.op2);
        check_field("rs2_data", rs2_data, e.rs2);
        check_field("imm_b", imm_b, e.imm_b);
        check_field("ctrl", {19'd0, ctrl}, {19'd0, e.ctrl});
        check_field("wb_addr", {27'd0, wb_addr}, {27'd0, e.wb_addr});
    endtask

    // one cycle of stimulus with the bundle due two negedges later
    task automatic drive(input logic [31:0] i, input logic [31:0] p, input logic ms,
                         input logic fl, input int wsel, input logic [4:0] wa,
                         input bundle_t e, input logic ehz);
        exp_item_t it;
        @(posedge clk);
        inst <= i;
        pc <= p;
        mem_stall <= ms;
        flush <= fl;
        exe_rf_wen <= (wsel == 1);
        mem_rf_wen <= (wsel == 2);
        wb_rf_wen <= (wsel == 3);
        exe_wb_addr <= (wsel == 1) ? wa : 5'd0;
        mem_wb_addr <= (wsel == 2) ? wa : 5'd0;
        wb_wb_addr <= (wsel == 3) ? wa : 5'd0;
        it.due = ncount + 2;
        it.b = e;
        exp_q.push_back(it);
        @(negedge clk);
        check_field("hazard_stall", {31'd0, hazard_stall}, {31'd0, ehz});
    endtask

    always @(negedge clk) begin
        ncount++;
        while (exp_q.size() > 0 && exp_q[0].due <= ncount) begin
            check_bundle(exp_q[0].b);
            void'(exp_q.pop_front());
        end
    end

    task automatic finish_run();
        $display("errors: %0d check, %0d timeout", check_errs, timeout_errs);
        if (check_errs == 0 && timeout_errs == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    endtask

    initial begin
        logic [31:0] a, b, pa, pb, d;
        logic [4:0] wa;
        int ws, n, w;
        bundle_t nop_b;
        void'($urandom(16706));
        inst = `DEC_INST_NOP;
        pc = 32'd0;
        mem_stall = 1'b0;
        flush = 1'b0;
        exe_rf_wen = 1'b0;
        mem_rf_wen = 1'b0;
        wb_rf_wen = 1'b0;
        exe_wb_addr = '0;
        mem_wb_addr = '0;
        wb_wb_addr = '0;
        wb_wen = 1'b0;
        wb_waddr = '0;
        wb_wdata = '0;
        for (int r = 0; r < 32; r++)
            shadow[r] = 32'd0;

        for (w = 0; w < 100 && arst_n !== 1'b1; w++)
            @(negedge clk);
        if (arst_n !== 1'b1) begin
            timeout_errs++;
            $display("timeout waiting for reset release");
        end else begin
            check_bundle(bubble());
            check_field("hazard_stall", {31'd0, hazard_stall}, 32'd0);

            for (int r = 1; r < 32; r++) begin
                @(posedge clk);
                d = $urandom;
                wb_wen <= 1'b1;
                wb_waddr <= 5'(r);
                wb_wdata <= d;
                shadow[r] = d;
            end
            @(posedge clk);
            wb_wen <= 1'b0;

            repeat (300) begin
                a = rand_inst();
                pa = rand_pc();
                drive(a, pa, 1'b0, 1'b0, 0, 5'd0, decode_ref(a, pa), 1'b0);
            end

            // data hazards with inst changing while held
            repeat (30) begin
                a = rand_inst();
                a[19:15] = 5'($urandom_range(1, 31));
                pa = rand_pc();
                ws = $urandom_range(1, 3);
                wa = ($urandom_range(0, 1) == 1 && a[24:20] != 5'd0) ? a[24:20] : a[19:15];
                n = $urandom_range(1, 3);
                drive(a, pa, 1'b0, 1'b0, ws, wa, bubble(), 1'b1);
                for (int c = 1; c < n; c++)
                    drive(rand_inst(), rand_pc(), 1'b0, 1'b0, ws, wa, bubble(), 1'b1);
                drive(rand_inst(), rand_pc(), 1'b0, 1'b0, 0, 5'd0, decode_ref(a, pa), 1'b0);
                a[19:15] = 5'd0;
                a[24:20] = 5'd0;
                drive(a, pa, 1'b0, 1'b0, ws, 5'd0, decode_ref(a, pa), 1'b0);
            end

            repeat (20) begin
                a = rand_inst();
                pa = rand_pc();
                n = $urandom_range(1, 5);
                drive(a, pa, 1'b1, 1'b0, 0, 5'd0, bubble(), 1'b0);
                for (int c = 1; c < n; c++)
                    drive(rand_inst(), rand_pc(), 1'b1, 1'b0, 0, 5'd0, bubble(), 1'b0);
                b = rand_inst();
                pb = rand_pc();
                drive(b, pb, 1'b0, 1'b0, 0, 5'd0, decode_ref(a, pa), 1'b0);
                drive(b, pb, 1'b0, 1'b0, 0, 5'd0, decode_ref(b, pb), 1'b0);
            end

            nop_b = decode_ref(`DEC_INST_NOP, `DEC_PC_NOP);
            repeat (20) begin
                a = rand_inst();
                a[19:15] = 5'($urandom_range(1, 31));
                pa = rand_pc();
                ws = $urandom_range(1, 3);
                drive(a, pa, 1'b0, 1'b1, 0, 5'd0, nop_b, 1'b0);
                b = rand_inst();
                pb = rand_pc();
                drive(b, pb, 1'b0, 1'b0, 0, 5'd0, decode_ref(b, pb), 1'b0);
                drive(a, pa, 1'b0, 1'b1, ws, a[19:15], nop_b, 1'b0);
                drive(b, pb, 1'b0, 1'b0, 0, 5'd0, decode_ref(b, pb), 1'b0);
                // flush while a hazard is being held
                drive(a, pa, 1'b0, 1'b0, ws, a[19:15], bubble(), 1'b1);
                drive(rand_inst(), rand_pc(), 1'b0, 1'b1, ws, a[19:15], nop_b, 1'b0);
                drive(b, pb, 1'b0, 1'b0, 0, 5'd0, decode_ref(b, pb), 1'b0);
            end

            for (w = 0; w < 10 && exp_q.size() > 0; w++)
                @(negedge clk);
            if (exp_q.size() > 0) begin
                timeout_errs++;
                $display("timeout waiting for the last bundles to be checked");
            end
        end
        finish_run();
    end

endmodule

// ==== tb.f ====
+incdir+source
source/decode_pkg.sv
source/instr_decoder.sv
source/hazard_unit.sv
source/reg_file.sv
source/issue_register.sv
source/decode_top.sv
verif/tb_clock_gen.sv
verif/tb_decode.sv

// ==== Makefile ====
TOOL     := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tb_decode
FILELIST := tb.f
OBJDIR   := obj_dir
PASS_MSG := Test completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the decode stage testbench"
	@echo "  clean  remove the build directory"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
